/* include/hps_config.svh */
`ifndef HPS_CONFIG_SVH
`define HPS_CONFIG_SVH

// clk_100 cycles per half period of the ps2 clock
`define HPS_PS2_DIV 4

// log2 of the ps2 fifo depth
`define HPS_FIFO_BITS 4

// core configuration string, first character is read first
`define HPS_CONF_STR "CORE;V1;"
`define HPS_CONF_LEN 8

// host command codes
`define HPS_CMD_CFG    16'h0001
`define HPS_CMD_JOY0   16'h0002
`define HPS_CMD_JOY1   16'h0003
`define HPS_CMD_MOUSE  16'h0004
`define HPS_CMD_KBD    16'h0005
`define HPS_CMD_CONF   16'h0014
`define HPS_CMD_STATUS 16'h001e
`define HPS_CMD_LEDS   16'h001f
`define HPS_CMD_PS2RD  16'h0021

`endif

/* rtl/hps_pkg.sv */
`default_nettype none

package hps_pkg;

	// host bus word
	typedef logic [15:0] hps_word_t;

	// one ps2 byte
	typedef logic [7:0] ps2_byte_t;

	// host read word, has_data on top
	typedef logic [8:0] ps2_rdata_t;

	typedef logic [31:0] status_t;

	typedef enum logic [2:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_parity,
		tx_stop,
		tx_done
	} ps2_tx_state_t;

	typedef enum logic [2:0] {
		rx_idle,
		rx_ack_start,
		rx_shift,
		rx_wait_stop,
		rx_ack
	} ps2_rx_state_t;

endpackage

`default_nettype wire

/* rtl/ps2_host_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ps2_host_if
	import hps_pkg::*;
();

	// byte pushed into the device fifo
	ps2_byte_t  wdata;
	logic       we;

	// received byte with its has_data flag
	ps2_rdata_t rdata;
	logic       rd;

	modport cmd (
		output wdata,
		output we,
		output rd,
		input  rdata
	);

	modport dev (
		input  wdata,
		input  we,
		input  rd,
		output rdata
	);

endinterface

`default_nettype wire

/* rtl/hps_cmd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hps_config.svh"

module hps_cmd_decoder
	import hps_pkg::*;
(
	input  logic        clk_100,
	input  logic        reset,
	input  logic        io_enable,
	input  logic        io_strobe,
	input  hps_word_t   io_din,
	output hps_word_t   io_dout,
	output logic [1:0]  buttons,
	output hps_word_t   joystick_0,
	output hps_word_t   joystick_1,
	output status_t     status,
	ps2_host_if.cmd     kbd,
	ps2_host_if.cmd     mouse
);

	localparam logic [8*`HPS_CONF_LEN-1:0] conf_str = `HPS_CONF_STR;

	hps_word_t  cmd;
	logic [9:0] byte_cnt;
	logic [7:0] cfg;

	assign buttons = cfg[1:0];

	//////////////////////////////////////////////////
	// command decode
	//////////////////////////////////////////////////

	always_ff @(posedge clk_100) begin
		if (reset) begin
			cmd        <= '0;
			byte_cnt   <= '0;
			io_dout    <= '0;
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			kbd.we     <= 1'b0;
			kbd.rd     <= 1'b0;
			mouse.we   <= 1'b0;
			mouse.rd   <= 1'b0;
		end else begin
			// one-cycle pulses
			kbd.we   <= 1'b0;
			kbd.rd   <= 1'b0;
			mouse.we <= 1'b0;
			mouse.rd <= 1'b0;

			if (!io_enable) begin
				byte_cnt <= '0;
				io_dout  <= '0;
			end else if (io_strobe) begin
				io_dout <= '0;
				// count saturates on long transfers
				if (~&byte_cnt)
					byte_cnt <= byte_cnt + 1'b1;

				if (byte_cnt == '0) begin
					cmd <= io_din;
				end else begin
					case (cmd)
						`HPS_CMD_CFG:  cfg        <= io_din[7:0];
						`HPS_CMD_JOY0: joystick_0 <= io_din;
						`HPS_CMD_JOY1: joystick_1 <= io_din;
						`HPS_CMD_MOUSE: begin
							mouse.wdata <= io_din[7:0];
							mouse.we    <= 1'b1;
						end
						`HPS_CMD_KBD: begin
							kbd.wdata <= io_din[7:0];
							kbd.we    <= 1'b1;
						end
						`HPS_CMD_CONF: begin
							// word n returns character n, zero past the end
							if (byte_cnt <= 10'(`HPS_CONF_LEN))
								io_dout <= {8'h00,
									conf_str[8*(`HPS_CONF_LEN - int'(byte_cnt)) +: 8]};
						end
						`HPS_CMD_STATUS: begin
							if (byte_cnt == 10'd1)
								status[15:0] <= io_din;
							else if (byte_cnt == 10'd2)
								status[31:16] <= io_din;
						end
						`HPS_CMD_LEDS: io_dout <= 16'h0100;
						`HPS_CMD_PS2RD: begin
							if (byte_cnt == 10'd1) begin
								io_dout <= {7'd0, kbd.rdata};
								kbd.rd  <= 1'b1;
							end else if (byte_cnt == 10'd2) begin
								io_dout  <= {7'd0, mouse.rdata};
								mouse.rd <= 1'b1;
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

	// host only strobes inside an enabled command
	a_strobe_in_enable: assert property (
		@(posedge clk_100) disable iff (reset) io_strobe |-> io_enable
	);

endmodule

`default_nettype wire

/* rtl/ps2_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hps_config.svh"

module ps2_clk_gen (
	input  logic clk_100,
	input  logic reset,
	output logic ps2_clk
);

	localparam int div      = `HPS_PS2_DIV;
	localparam int cnt_bits = (div > 1) ? $clog2(div) : 1;

	logic [cnt_bits-1:0] div_cnt;

	// toggle level, sampled as a clock enable by the devices
	always_ff @(posedge clk_100) begin
		if (reset) begin
			div_cnt <= '0;
			ps2_clk <= 1'b0;
		end else if (div_cnt == cnt_bits'(div - 1)) begin
			div_cnt <= '0;
			ps2_clk <= ~ps2_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* rtl/ps2_device.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hps_config.svh"

module ps2_device
	import hps_pkg::*;
(
	input  logic    clk_100,
	input  logic    reset,
	ps2_host_if.dev host,
	input  logic    ps2_clk,
	input  logic    ps2_clk_in,
	input  logic    ps2_data_in,
	output logic    ps2_clk_out,
	output logic    ps2_data_out
);

	localparam int fb = `HPS_FIFO_BITS;

	ps2_byte_t     fifo [0:(1<<fb)-1];
	logic [fb:0]   wptr;
	logic [fb:0]   rptr;
	logic          fifo_empty;
	logic          fifo_full;

	ps2_tx_state_t tx_state;
	ps2_rx_state_t rx_state;
	ps2_byte_t     tx_byte;
	logic          tx_par;
	logic [3:0]    tx_cnt;
	logic [1:0]    idle_cnt;
	ps2_byte_t     rx_byte;
	logic [3:0]    rx_cnt;
	logic          has_data;

	logic          c1, c2, d1;
	logic          old_clk;
	logic          clk_rise;
	logic          clk_fall;
	logic          lines_idle;
	logic          tx_busy;
	logic          rx_busy;

	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[fb] != rptr[fb]) && (wptr[fb-1:0] == rptr[fb-1:0]);
	assign clk_rise   = ~old_clk & ps2_clk;
	assign clk_fall   = old_clk & ~ps2_clk;
	assign lines_idle = c2 & c1 & d1;
	assign tx_busy    = tx_state inside {tx_start, tx_data, tx_parity, tx_stop};
	// receiver drives the clock once past the start
	assign rx_busy    = rx_state inside {rx_shift, rx_wait_stop, rx_ack};
	assign host.rdata = {has_data, rx_byte};

	// fifo storage
	always_ff @(posedge clk_100) begin
		if (host.we)
			fifo[wptr[fb-1:0]] <= host.wdata;
	end

	//////////////////////////////////////////////////
	// transmitter and receiver
	//////////////////////////////////////////////////

	always_ff @(posedge clk_100) begin
		if (reset) begin
			wptr <= '0;
			rptr <= '0;
			tx_state <= tx_idle;
			rx_state <= rx_idle;
			tx_cnt <= '0;
			rx_cnt <= '0;
			idle_cnt <= '0;
			rx_byte <= '0;
			has_data <= 1'b0;
			{c1, c2, d1} <= 3'b111;
			old_clk <= 1'b0;
			ps2_clk_out <= 1'b1;
			ps2_data_out <= 1'b1;
		end else begin
			if (host.we)
				wptr <= wptr + 1'b1;
			if (host.rd)
				has_data <= 1'b0;

			c1 <= ps2_clk_in;
			c2 <= c1;
			d1 <= ps2_data_in;
			old_clk <= ps2_clk;

			// host released its clock with data held low
			if (rx_state == rx_idle && tx_state == tx_idle && ~c2 && c1 && ~d1)
				rx_state <= rx_ack_start;

			if (clk_rise) begin
				ps2_clk_out <= 1'b1;
				if (rx_state != rx_idle) begin
					case (rx_state)
						rx_ack_start: begin
							rx_state <= rx_shift;
							rx_cnt <= '0;
						end
						rx_shift: begin
							// lsb first, the ninth edge skips parity
							if (rx_cnt <= 4'd7)
								rx_byte <= {d1, rx_byte[7:1]};
							else
								rx_state <= rx_wait_stop;
							rx_cnt <= rx_cnt + 1'b1;
						end
						rx_wait_stop: begin
							if (d1) begin
								rx_state <= rx_ack;
								ps2_data_out <= 1'b0;
							end
						end
						default: begin
							ps2_data_out <= 1'b1;
							has_data <= 1'b1;
							rx_state <= rx_idle;
						end
					endcase
				end else begin
					case (tx_state)
						tx_idle: begin
							if (!lines_idle) begin
								idle_cnt <= '0;
							end else if (idle_cnt != 2'd3) begin
								idle_cnt <= idle_cnt + 1'b1;
							end else if (!fifo_empty) begin
								tx_byte <= fifo[rptr[fb-1:0]];
								rptr <= rptr + 1'b1;
								tx_par <= 1'b1;
								idle_cnt <= '0;
								tx_state <= tx_start;
								// start bit
								ps2_data_out <= 1'b0;
							end
						end
						tx_start, tx_data: begin
							if (tx_state == tx_data && tx_cnt == 4'd8) begin
								ps2_data_out <= tx_par;
								tx_state <= tx_parity;
							end else begin
								ps2_data_out <= tx_byte[0];
								tx_byte <= {1'b0, tx_byte[7:1]};
								tx_par <= tx_par ^ tx_byte[0];
								tx_cnt <= (tx_state == tx_start) ? 4'd1 : tx_cnt + 1'b1;
								tx_state <= tx_data;
							end
						end
						tx_parity: begin
							ps2_data_out <= 1'b1;
							tx_state <= tx_stop;
						end
						tx_stop: tx_state <= tx_done;
						default: tx_state <= tx_idle;
					endcase
				end
			end

			if (clk_fall)
				ps2_clk_out <= !(tx_busy || rx_busy);
		end
	end

	a_tx_rx_exclusive: assert property (
		@(posedge clk_100) disable iff (reset)
		!((tx_state != tx_idle) && (rx_state != rx_idle))
	);

	// no back-pressure, a push into a full fifo loses the byte
	a_no_overflow: assert property (
		@(posedge clk_100) disable iff (reset) host.we |-> !fifo_full
	);

endmodule

`default_nettype wire

/* rtl/hps_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hps_io_top
	import hps_pkg::*;
(
	input  logic       clk_100,
	input  logic       reset,
	input  logic       io_enable,
	input  logic       io_strobe,
	input  hps_word_t  io_din,
	output hps_word_t  io_dout,
	output logic [1:0] buttons,
	output hps_word_t  joystick_0,
	output hps_word_t  joystick_1,
	output status_t    status,
	output logic       ps2_kbd_clk_out,
	output logic       ps2_kbd_data_out,
	output logic       ps2_mouse_clk_out,
	output logic       ps2_mouse_data_out,
	input  logic       ps2_kbd_clk_in,
	input  logic       ps2_kbd_data_in,
	input  logic       ps2_mouse_clk_in,
	input  logic       ps2_mouse_data_in
);

	logic ps2_clk;

	ps2_host_if kbd_if ();
	ps2_host_if mouse_if ();

	hps_cmd_decoder u_cmd_decoder (
		.clk_100    (clk_100),
		.reset      (reset),
		.io_enable  (io_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.io_dout    (io_dout),
		.buttons    (buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.kbd        (kbd_if.cmd),
		.mouse      (mouse_if.cmd)
	);

	// one bit clock shared by both devices
	ps2_clk_gen u_ps2_clk_gen (
		.clk_100 (clk_100),
		.reset   (reset),
		.ps2_clk (ps2_clk)
	);

	ps2_device u_keyboard (
		.clk_100      (clk_100),
		.reset        (reset),
		.host         (kbd_if.dev),
		.ps2_clk      (ps2_clk),
		.ps2_clk_in   (ps2_kbd_clk_in),
		.ps2_data_in  (ps2_kbd_data_in),
		.ps2_clk_out  (ps2_kbd_clk_out),
		.ps2_data_out (ps2_kbd_data_out)
	);

	ps2_device u_mouse (
		.clk_100      (clk_100),
		.reset        (reset),
		.host         (mouse_if.dev),
		.ps2_clk      (ps2_clk),
		.ps2_clk_in   (ps2_mouse_clk_in),
		.ps2_data_in  (ps2_mouse_data_in),
		.ps2_clk_out  (ps2_mouse_clk_out),
		.ps2_data_out (ps2_mouse_data_out)
	);

endmodule

`default_nettype wire

/* bench/ps2_host_model.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_host_model
	import hps_pkg::*;
(
	input  logic      clk_100,
	input  logic      ps2_clk_out,
	input  logic      ps2_data_out,
	output logic      ps2_clk_in,
	output logic      ps2_data_in,
	output ps2_byte_t rx_byte,
	output int        rx_count,
	output int        fall_count,
	output int        err_count
);

	logic [10:0] frame;
	int          bit_cnt;
	logic        sending;

	// idle bus, both lines released high
	initial begin
		ps2_clk_in  = 1'b1;
		ps2_data_in = 1'b1;
		rx_byte     = '0;
		rx_count    = 0;
		fall_count  = 0;
		err_count   = 0;
		bit_cnt     = 0;
		sending     = 1'b0;
	end

	//////////////////////////////////////////////////
	// device to host frames
	//////////////////////////////////////////////////

	always @(negedge ps2_clk_out) begin
		if (!sending) begin
			fall_count = fall_count + 1;
			frame[bit_cnt] = ps2_data_out;
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 11) begin
				// start low, odd parity over data and parity, stop high
				if (frame[0] !== 1'b0 || (^frame[9:1]) !== 1'b1 || frame[10] !== 1'b1) begin
					$display("frame error in %m: start %b parity %b stop %b",
						frame[0], frame[9], frame[10]);
					err_count = err_count + 1;
				end
				rx_byte  = frame[8:1];
				rx_count = rx_count + 1;
				bit_cnt  = 0;
			end
		end
	end

	//////////////////////////////////////////////////
	// host to device frame
	//////////////////////////////////////////////////

	task automatic send_byte(input ps2_byte_t value);
		logic [9:0] bits;
		int         i;
		// data bits, odd parity, stop
		bits = {1'b1, ~^value, value};
		sending = 1'b1;
		@(negedge clk_100);
		ps2_clk_in = 1'b0;
		repeat (4) @(negedge clk_100);
		ps2_data_in = 1'b0;
		repeat (2) @(negedge clk_100);
		// release the clock with data still low
		ps2_clk_in = 1'b1;
		repeat (4) @(negedge clk_100);
		ps2_data_in = bits[0];
		for (i = 1; i < 10; i++) begin
			@(posedge ps2_clk_out);
			@(negedge clk_100);
			ps2_data_in = bits[i];
		end
		@(posedge ps2_clk_out);
		@(negedge ps2_clk_out);
		if (ps2_data_out !== 1'b0) begin
			$display("device in %m did not acknowledge the host frame");
			err_count = err_count + 1;
		end
		@(posedge ps2_clk_out);
		@(negedge clk_100);
		ps2_data_in = 1'b1;
		sending = 1'b0;
	endtask

endmodule

`default_nettype wire

/* bench/hps_io_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hps_config.svh"

module hps_io_tb
	import hps_pkg::*;
();

	localparam int clk_ns       = 100;
	localparam int bit_ns       = 2 * `HPS_PS2_DIV * clk_ns;
	localparam int frame_cycles = 40 * 2 * `HPS_PS2_DIV;
	localparam int n_tests      = 11;
	localparam int max_words    = 10;

	// kinds of result
	localparam int k_read    = 0;
	localparam int k_buttons = 1;
	localparam int k_joy0    = 2;
	localparam int k_joy1    = 3;
	localparam int k_status  = 4;
	localparam int k_kbd     = 5;
	localparam int k_mouse   = 6;
	localparam int k_send    = 7;
	localparam int k_rdata   = 8;

	logic       clk_100;
	logic       reset;
	logic       io_enable;
	logic       io_strobe;
	hps_word_t  io_din;
	hps_word_t  io_dout;
	logic [1:0] buttons;
	hps_word_t  joystick_0;
	hps_word_t  joystick_1;
	status_t    status;
	logic       kbd_clk_out, kbd_data_out, kbd_clk_in, kbd_data_in;
	logic       mouse_clk_out, mouse_data_out, mouse_clk_in, mouse_data_in;
	ps2_byte_t  kbd_rx_byte, mouse_rx_byte;
	int         kbd_rx_count, kbd_falls, kbd_err;
	int         mouse_rx_count, mouse_falls, mouse_err;

	// stimulus and expected values
	string      t_name [n_tests];
	hps_word_t  t_cmd  [n_tests];
	int         t_len  [n_tests];
	int         t_kind [n_tests];
	ps2_byte_t  t_send [n_tests];
	hps_word_t  t_data [n_tests][max_words];
	hps_word_t  t_exp  [n_tests][max_words];
	hps_word_t  rd_word [max_words];

	int         test_errors;
	int         passed;
	int         failed;

	hps_io_top u_hps_io_top (
		.clk_100            (clk_100),
		.reset              (reset),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ps2_kbd_clk_out    (kbd_clk_out),
		.ps2_kbd_data_out   (kbd_data_out),
		.ps2_mouse_clk_out  (mouse_clk_out),
		.ps2_mouse_data_out (mouse_data_out),
		.ps2_kbd_clk_in     (kbd_clk_in),
		.ps2_kbd_data_in    (kbd_data_in),
		.ps2_mouse_clk_in   (mouse_clk_in),
		.ps2_mouse_data_in  (mouse_data_in)
	);

	ps2_host_model u_kbd_host (
		.clk_100 (clk_100), .ps2_clk_out (kbd_clk_out), .ps2_data_out (kbd_data_out),
		.ps2_clk_in (kbd_clk_in), .ps2_data_in (kbd_data_in), .rx_byte (kbd_rx_byte),
		.rx_count (kbd_rx_count), .fall_count (kbd_falls), .err_count (kbd_err)
	);

	ps2_host_model u_mouse_host (
		.clk_100 (clk_100), .ps2_clk_out (mouse_clk_out), .ps2_data_out (mouse_data_out),
		.ps2_clk_in (mouse_clk_in), .ps2_data_in (mouse_data_in), .rx_byte (mouse_rx_byte),
		.rx_count (mouse_rx_count), .fall_count (mouse_falls), .err_count (mouse_err)
	);

	initial clk_100 = 1'b0;
	always #(clk_ns / 2) clk_100 = ~clk_100;

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input hps_word_t exp, input hps_word_t act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_status(input string name, input status_t exp, input status_t act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_byte(input string name, input ps2_byte_t exp, input ps2_byte_t act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_rdata(input string name, input ps2_rdata_t exp, input ps2_rdata_t act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			$display("pass %s", name);
			passed++;
		end else begin
			$display("fail %s with %0d mismatches", name, test_errors);
			failed++;
		end
		test_errors = 0;
	endtask

	task automatic set_entry(input int idx, input string name, input hps_word_t cmd,
		input int kind, input int len);
		t_name[idx] = name;
		t_cmd[idx]  = cmd;
		t_kind[idx] = kind;
		t_len[idx]  = len;
	endtask

	task automatic build_table();
		string     conf;
		ps2_byte_t b;
		int        i;
		int        j;
		conf = `HPS_CONF_STR;
		for (i = 0; i < n_tests; i++) begin
			t_send[i] = '0;
			for (j = 0; j < max_words; j++) begin
				t_data[i][j] = '0;
				t_exp[i][j]  = '0;
			end
		end
		set_entry(0, "unknown_cmd", 16'h0077, k_read, 2);
		set_entry(1, "leds_read", `HPS_CMD_LEDS, k_read, 2);
		t_exp[1][0] = 16'h0100;
		t_exp[1][1] = 16'h0100;
		// buttons are the low two bits of the cfg byte
		set_entry(2, "cfg_write", `HPS_CMD_CFG, k_buttons, 1);
		t_data[2][0] = 16'h00a6;
		t_exp[2][0]  = t_data[2][0] & 16'h0003;
		set_entry(3, "joy0_write", `HPS_CMD_JOY0, k_joy0, 1);
		t_data[3][0] = hps_word_t'($urandom);
		t_exp[3][0]  = t_data[3][0];
		set_entry(4, "joy1_write", `HPS_CMD_JOY1, k_joy1, 1);
		t_data[4][0] = hps_word_t'($urandom);
		t_exp[4][0]  = t_data[4][0];
		// low word first
		set_entry(5, "status_write", `HPS_CMD_STATUS, k_status, 2);
		for (j = 0; j < 2; j++) begin
			t_data[5][j] = hps_word_t'($urandom);
			t_exp[5][j]  = t_data[5][j];
		end
		set_entry(6, "conf_read", `HPS_CMD_CONF, k_read, `HPS_CONF_LEN + 1);
		for (j = 0; j < `HPS_CONF_LEN; j++)
			t_exp[6][j] = {8'h00, conf[j]};
		set_entry(7, "kbd_bytes", `HPS_CMD_KBD, k_kbd, 3);
		for (j = 0; j < 3; j++) begin
			t_data[7][j] = hps_word_t'($urandom % 256);
			t_exp[7][j]  = t_data[7][j];
		end
		set_entry(8, "mouse_byte", `HPS_CMD_MOUSE, k_mouse, 1);
		t_data[8][0] = hps_word_t'($urandom % 256);
		t_exp[8][0]  = t_data[8][0];
		// host frame into the keyboard, then two host reads
		b = ps2_byte_t'($urandom % 256);
		set_entry(9, "kbd_host_send", `HPS_CMD_PS2RD, k_send, 2);
		t_send[9]   = b;
		t_exp[9][0] = {7'd0, 1'b1, b};
		set_entry(10, "ps2_read_again", `HPS_CMD_PS2RD, k_rdata, 1);
		t_exp[10][0] = {7'd0, 1'b0, b};
	endtask

	//////////////////////////////////////////////////
	// bus and frame tasks
	//////////////////////////////////////////////////

	task automatic run_command(input hps_word_t cmd, input int len, input int idx);
		int i;
		@(negedge clk_100);
		io_enable = 1'b1;
		io_strobe = 1'b1;
		io_din    = cmd;
		@(negedge clk_100);
		io_strobe = 1'b0;
		for (i = 0; i < len; i++) begin
			@(negedge clk_100);
			io_strobe = 1'b1;
			io_din    = t_data[idx][i];
			// read word is registered on the strobe edge
			@(negedge clk_100);
			io_strobe  = 1'b0;
			rd_word[i] = io_dout;
		end
		@(negedge clk_100);
		io_enable = 1'b0;
	endtask

	task automatic wait_frame(input int host_sel, input int target, input string name);
		int waited;
		int count;
		waited = 0;
		count  = (host_sel == 0) ? kbd_rx_count : mouse_rx_count;
		while (count < target && waited < frame_cycles) begin
			@(negedge clk_100);
			waited++;
			count = (host_sel == 0) ? kbd_rx_count : mouse_rx_count;
		end
		if (count < target) begin
			$display("%s: device sent no PS/2 frame within %0d cycles", name, frame_cycles);
			test_errors++;
		end
	endtask

	task automatic apply_test(input int idx);
		string name;
		int    i;
		int    base;
		int    falls_base;
		name = t_name[idx];
		base = (t_kind[idx] == k_mouse) ? mouse_rx_count : kbd_rx_count;
		falls_base = kbd_falls;
		if (t_kind[idx] == k_send)
			u_kbd_host.send_byte(t_send[idx]);
		run_command(t_cmd[idx], t_len[idx], idx);
		case (t_kind[idx])
			k_read: begin
				for (i = 0; i < t_len[idx]; i++)
					check_word(name, t_exp[idx][i], rd_word[i]);
			end
			k_buttons: check_word(name, t_exp[idx][0], {14'd0, buttons});
			k_joy0:    check_word(name, t_exp[idx][0], joystick_0);
			k_joy1:    check_word(name, t_exp[idx][0], joystick_1);
			k_status:  check_status(name, {t_exp[idx][1], t_exp[idx][0]}, status);
			k_kbd: begin
				for (i = 0; i < t_len[idx]; i++) begin
					wait_frame(0, base + i + 1, name);
					check_byte(name, t_exp[idx][i][7:0], kbd_rx_byte);
				end
				check_word(name, 16'd0, 16'(kbd_err));
				// mouse clock never toggled
				check_word(name, 16'd0, 16'(mouse_falls));
			end
			k_mouse: begin
				wait_frame(1, base + 1, name);
				check_byte(name, t_exp[idx][0][7:0], mouse_rx_byte);
				check_word(name, 16'd0, 16'(mouse_err));
				// keyboard clock stayed idle
				check_word(name, 16'd0, 16'(kbd_falls - falls_base));
			end
			default: begin
				for (i = 0; i < t_len[idx]; i++)
					check_rdata(name, t_exp[idx][i][8:0], rd_word[i][8:0]);
				// host frame acknowledged by the device
				if (t_kind[idx] == k_send)
					check_word(name, 16'd0, 16'(kbd_err));
			end
		endcase
		finish_test(name);
	endtask

	//////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		int seed;
		int k;
		reset       = 1'b1;
		io_enable   = 1'b0;
		io_strobe   = 1'b0;
		io_din      = '0;
		test_errors = 0;
		passed      = 0;
		failed      = 0;
		seed = $urandom(16);
		build_table();
		repeat (8) @(negedge clk_100);
		reset = 1'b0;
		@(negedge clk_100);

		// outputs cleared, ps2 lines released
		check_word("reset_state", 16'd0, io_dout);
		check_word("reset_state", 16'd0, {14'd0, buttons});
		check_word("reset_state", 16'd0, joystick_0);
		check_word("reset_state", 16'd0, joystick_1);
		check_status("reset_state", 32'd0, status);
		check_word("reset_state", 16'h000f,
			{12'd0, kbd_clk_out, kbd_data_out, mouse_clk_out, mouse_data_out});
		finish_test("reset_state");

		for (k = 0; k < n_tests; k++)
			apply_test(k);

		$display("passed %0d failed %0d", passed, failed);
		if (failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(n_tests * 40 * bit_ns);
		$display("run timed out after %0d ns before all tests finished", n_tests * 40 * bit_ns);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
rtl/hps_pkg.sv
rtl/ps2_host_if.sv
rtl/hps_cmd_decoder.sv
rtl/ps2_clk_gen.sv
rtl/ps2_device.sv
rtl/hps_io_top.sv
bench/ps2_host_model.sv
bench/hps_io_tb.sv
